// File: common/sram_defs.svh
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// start of the sram window in the core address map
`define SRAM_BASE_ADDR 32'h8000_0000

// bank count and its log2, kept in step by hand
`define SRAM_NUM_BANKS 4
`define SRAM_LOG_BANKS 2

// log2 of words per bank, 64 words in the simulated default
`define SRAM_LOG_BANK_WORDS 6

// window end is base + banks * words * 4 bytes
// decoder derives it from the values above

`endif

// File: common/sram_pkg.sv
`default_nettype none

package sram_pkg;

    `include "sram_defs.svh"

    // bus data word
    typedef logic [31:0] word_t;

    // byte address on both ports
    typedef logic [31:0] addr_t;

    // byte enables, bit n covers byte lane n
    typedef logic [3:0] be_t;

    // one-hot bank select, one bit per bank
    typedef logic [`SRAM_NUM_BANKS-1:0] bank_sel_t;

    // word index inside a bank
    typedef logic [`SRAM_LOG_BANK_WORDS-1:0] bank_addr_t;

    // bank number taken from the address
    typedef logic [`SRAM_LOG_BANKS-1:0] bank_num_t;

    // returned for any access outside the window
    localparam word_t ILLEGAL_RDATA = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// File: common/bank_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

// data port request as seen by the bank array
interface bank_wr_if
    import sram_pkg::*;
();

    // one-hot, all zero for an idle or illegal request
    bank_sel_t  sel;
    // write strobe, only set for a legal write
    logic       we;
    be_t        be;
    // word index shared by every bank
    bank_addr_t addr;
    word_t      wdata;

    // decode side drives everything
    modport decoder
    (
        output sel,
        output we,
        output be,
        output addr,
        output wdata
    );

    // bank side only listens
    modport array
    (
        input sel,
        input we,
        input be,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

// File: hdl/sram_addr_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_defs.svh"

module sram_addr_decode
    import sram_pkg::*;
(
    input  wire logic  d_req_i,
    input  wire addr_t d_addr_i,
    input  wire logic  d_we_i,
    input  wire be_t   d_be_i,
    input  wire word_t d_wdata_i,
    input  wire logic  i_req_i,
    input  wire addr_t i_addr_i,

    output logic       d_gnt_o,
    output logic       i_gnt_o,
    output logic       d_illegal_o,
    output logic       i_illegal_o,
    output bank_sel_t  inst_sel_o,
    output bank_addr_t inst_addr_o,

    bank_wr_if.decoder d_bank
);

    // byte offset of the bank number inside an address
    localparam int BANK_LSB = `SRAM_LOG_BANK_WORDS + 2;
    localparam addr_t WIN_BASE = `SRAM_BASE_ADDR;
    localparam addr_t WIN_END = 32'(`SRAM_BASE_ADDR
        + `SRAM_NUM_BANKS * (2 ** `SRAM_LOG_BANK_WORDS) * 4);

    logic      d_legal;
    logic      i_legal;
    bank_num_t d_bank_num;
    bank_num_t i_bank_num;

    // end address is exclusive
    function automatic logic in_window(input addr_t addr);
        return (addr >= WIN_BASE) && (addr < WIN_END);
    endfunction

    function automatic bank_sel_t make_sel(input logic hit, input bank_num_t num);
        bank_sel_t sel;
        sel = '0;
        if (hit)
        begin
            sel[num] = 1'b1;
        end
        return sel;
    endfunction

    always_comb
    begin
        d_legal    = in_window(d_addr_i);
        i_legal    = in_window(i_addr_i);
        d_bank_num = d_addr_i[BANK_LSB +: `SRAM_LOG_BANKS];
        i_bank_num = i_addr_i[BANK_LSB +: `SRAM_LOG_BANKS];
    end

    // no wait states, every request granted at once
    assign d_gnt_o = d_req_i;
    assign i_gnt_o = i_req_i;

    // flagged here, reported by the read mux a cycle later
    assign d_illegal_o = d_req_i && !d_legal;
    assign i_illegal_o = i_req_i && !i_legal;

    // data port towards the banks
    assign d_bank.sel   = make_sel(d_req_i && d_legal, d_bank_num);
    assign d_bank.we    = d_req_i && d_we_i && d_legal;
    assign d_bank.be    = d_be_i;
    assign d_bank.addr  = d_addr_i[BANK_LSB-1:2];
    assign d_bank.wdata = d_wdata_i;

    // instruction port, read only
    assign inst_sel_o  = make_sel(i_req_i && i_legal, i_bank_num);
    assign inst_addr_o = i_addr_i[BANK_LSB-1:2];

endmodule

`default_nettype wire

// File: sram_bank/sram_macro_1rw1r.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_defs.svh"

// model of a 1rw + 1r macro, controls active low
module sram_macro_1rw1r
    import sram_pkg::*;
(
    input  wire logic       clk_i,
    // port 0, read/write
    input  wire logic       csb0_i,
    input  wire logic       web0_i,
    input  wire be_t        wmask0_i,
    input  wire bank_addr_t addr0_i,
    input  wire word_t      din0_i,
    // port 1, read only
    input  wire logic       csb1_i,
    input  wire bank_addr_t addr1_i,

    output word_t           dout0_o,
    output word_t           dout1_o
);

    localparam int WORDS = 2 ** `SRAM_LOG_BANK_WORDS;

    word_t mem [WORDS];

    // port 0, byte masked write
    // read returns the word before this edge's update
    always_ff @(posedge clk_i)
    begin
        if (!csb0_i)
        begin
            dout0_o <= mem[addr0_i];
            if (!web0_i)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (wmask0_i[b])
                    begin
                        mem[addr0_i][8*b +: 8] <= din0_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // port 1 sees old data on a same word write
    always_ff @(posedge clk_i)
    begin
        if (!csb1_i)
        begin
            dout1_o <= mem[addr1_i];
        end
    end

endmodule

`default_nettype wire

// File: sram_bank/sram_bank_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_defs.svh"

module sram_bank_array
    import sram_pkg::*;
(
    input  wire logic       clk_i,

    // instruction port select and word index
    input  wire bank_sel_t  inst_sel_i,
    input  wire bank_addr_t inst_addr_i,

    // data port request from the decoder
    bank_wr_if.array        d_bank,

    // registered words, one per bank and port
    output word_t           d_read_vec_o [`SRAM_NUM_BANKS],
    output word_t           i_read_vec_o [`SRAM_NUM_BANKS]
);

    // active low controls per bank
    logic [`SRAM_NUM_BANKS-1:0] d_csb;
    logic [`SRAM_NUM_BANKS-1:0] i_csb;
    logic                       d_web;

    assign d_csb = ~d_bank.sel;
    assign i_csb = ~inst_sel_i;
    // shared by all banks, chip select picks the one that writes
    assign d_web = ~d_bank.we;

    genvar g;
    generate
        for (g = 0; g < `SRAM_NUM_BANKS; g++)
        begin : g_bank
            // address and write data fan out to every bank
            sram_macro_1rw1r u_macro
            (
                .clk_i    (clk_i),
                .csb0_i   (d_csb[g]),
                .web0_i   (d_web),
                .wmask0_i (d_bank.be),
                .addr0_i  (d_bank.addr),
                .din0_i   (d_bank.wdata),
                .csb1_i   (i_csb[g]),
                .addr1_i  (inst_addr_i),
                .dout0_o  (d_read_vec_o[g]),
                .dout1_o  (i_read_vec_o[g])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: hdl/sram_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_defs.svh"

module sram_read_mux
    import sram_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,

    // request side, same cycle as the bank select
    input  wire logic      d_req_i,
    input  wire logic      i_req_i,
    input  wire logic      d_illegal_i,
    input  wire logic      i_illegal_i,
    input  wire bank_sel_t d_sel_i,
    input  wire bank_sel_t i_sel_i,

    // bank outputs, valid one cycle after the select
    input  wire word_t     d_read_vec_i [`SRAM_NUM_BANKS],
    input  wire word_t     i_read_vec_i [`SRAM_NUM_BANKS],

    output logic           d_rvalid_o,
    output logic           i_rvalid_o,
    output word_t          d_rdata_o,
    output word_t          i_rdata_o,
    output logic           illegal_memory_o
);

    bank_sel_t d_sel_q;
    bank_sel_t i_sel_q;
    logic      d_req_q;
    logic      i_req_q;
    logic      d_ill_q;
    logic      i_ill_q;

    // zero when the select is empty
    function automatic word_t pick_word(input bank_sel_t sel,
                                        input word_t vec [`SRAM_NUM_BANKS]);
        word_t w;
        w = '0;
        for (int b = 0; b < `SRAM_NUM_BANKS; b++)
        begin
            if (sel[b])
            begin
                w = vec[b];
            end
        end
        return w;
    endfunction

    // line up request info with the macro output register
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            d_sel_q <= '0;
            i_sel_q <= '0;
            d_req_q <= 1'b0;
            i_req_q <= 1'b0;
            d_ill_q <= 1'b0;
            i_ill_q <= 1'b0;
        end
        else
        begin
            d_sel_q <= d_sel_i;
            i_sel_q <= i_sel_i;
            d_req_q <= d_req_i;
            i_req_q <= i_req_i;
            d_ill_q <= d_illegal_i;
            i_ill_q <= i_illegal_i;
        end
    end

    // writes get an rvalid too
    assign d_rvalid_o = d_req_q;
    assign i_rvalid_o = i_req_q;

    // illegal marker wins over bank data
    assign d_rdata_o = d_ill_q ? ILLEGAL_RDATA : pick_word(d_sel_q, d_read_vec_i);
    assign i_rdata_o = i_ill_q ? ILLEGAL_RDATA : pick_word(i_sel_q, i_read_vec_i);

    assign illegal_memory_o = d_ill_q | i_ill_q;

endmodule

`default_nettype wire

// File: hdl/sram_wrap.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_defs.svh"

module sram_wrap
    import sram_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,

    // data port, OBI style
    input  wire logic  sram_d_req_i,
    input  wire addr_t sram_d_addr_i,
    input  wire logic  sram_d_we_i,
    input  wire be_t   sram_d_be_i,
    input  wire word_t sram_d_wdata_i,
    output logic       sram_d_gnt_o,
    output logic       sram_d_rvalid_o,
    output word_t      sram_d_rdata_o,

    // instruction port, read only
    input  wire logic  sram_i_req_i,
    input  wire addr_t sram_i_addr_i,
    output logic       sram_i_gnt_o,
    output logic       sram_i_rvalid_o,
    output word_t      sram_i_rdata_o,

    // either port hit outside the window last cycle
    output logic       illegal_memory_o
);

    bank_sel_t  inst_sel;
    bank_addr_t inst_addr;
    logic       d_illegal;
    logic       i_illegal;
    word_t      d_read_vec [`SRAM_NUM_BANKS];
    word_t      i_read_vec [`SRAM_NUM_BANKS];

    // data port bank request
    bank_wr_if d_bank ();

    // combinational, grants and bank selects
    sram_addr_decode u_decode
    (
        .d_req_i     (sram_d_req_i),
        .d_addr_i    (sram_d_addr_i),
        .d_we_i      (sram_d_we_i),
        .d_be_i      (sram_d_be_i),
        .d_wdata_i   (sram_d_wdata_i),
        .i_req_i     (sram_i_req_i),
        .i_addr_i    (sram_i_addr_i),
        .d_gnt_o     (sram_d_gnt_o),
        .i_gnt_o     (sram_i_gnt_o),
        .d_illegal_o (d_illegal),
        .i_illegal_o (i_illegal),
        .inst_sel_o  (inst_sel),
        .inst_addr_o (inst_addr),
        .d_bank      (d_bank.decoder)
    );

    sram_bank_array u_banks
    (
        .clk_i        (clk_i),
        .inst_sel_i   (inst_sel),
        .inst_addr_i  (inst_addr),
        .d_bank       (d_bank.array),
        .d_read_vec_o (d_read_vec),
        .i_read_vec_o (i_read_vec)
    );

    // response stage, one cycle after the request
    sram_read_mux u_read_mux
    (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .d_req_i          (sram_d_req_i),
        .i_req_i          (sram_i_req_i),
        .d_illegal_i      (d_illegal),
        .i_illegal_i      (i_illegal),
        .d_sel_i          (d_bank.sel),
        .i_sel_i          (inst_sel),
        .d_read_vec_i     (d_read_vec),
        .i_read_vec_i     (i_read_vec),
        .d_rvalid_o       (sram_d_rvalid_o),
        .i_rvalid_o       (sram_i_rvalid_o),
        .d_rdata_o        (sram_d_rdata_o),
        .i_rdata_o        (sram_i_rdata_o),
        .illegal_memory_o (illegal_memory_o)
    );

endmodule

`default_nettype wire

// File: sim/sram_wrap_asserts.sv
`timescale 1ns/100ps
`default_nettype none

// handshake and reset rules, bound into sram_wrap
module sram_wrap_asserts
(
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic d_req_i,
    input wire logic d_gnt_i,
    input wire logic d_rvalid_i,
    input wire logic i_req_i,
    input wire logic i_gnt_i,
    input wire logic i_rvalid_i,
    input wire logic illegal_i
);

    // assertion failures so far
    int fail_count = 0;

    // no wait states on either port
    a_d_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i) d_gnt_i == d_req_i)
        else
        begin
            fail_count++;
            $error("data port gnt differs from req");
        end
    a_i_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i) i_gnt_i == i_req_i)
        else
        begin
            fail_count++;
            $error("instruction port gnt differs from req");
        end

    // response one cycle after each request, never otherwise
    a_d_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> d_rvalid_i == $past(d_req_i))
        else
        begin
            fail_count++;
            $error("data port rvalid does not follow req by one cycle");
        end
    a_i_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> i_rvalid_i == $past(i_req_i))
        else
        begin
            fail_count++;
            $error("instruction port rvalid does not follow req by one cycle");
        end

    // response registers cleared by the reset edge
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !d_rvalid_i && !i_rvalid_i && !illegal_i)
        else
        begin
            fail_count++;
            $error("rvalid or illegal_memory_o set in the cycle after reset");
        end

endmodule

`default_nettype wire

// File: sim/sram_wrap_checker.sv
`timescale 1ns/100ps
`default_nettype none

// scores every request once its response cycle has passed
module sram_wrap_checker
    import sram_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    input  wire logic  d_req_i,
    input  wire logic  d_rvalid_i,
    input  wire word_t d_rdata_i,
    input  wire logic  i_req_i,
    input  wire logic  i_rvalid_i,
    input  wire word_t i_rdata_i,
    input  wire logic  illegal_i,
    output int         fail_count_o,
    output int         open_count_o
);

    // entry is {is_read, illegal, expected word}
    string       d_name_q [$];
    string       i_name_q [$];
    logic [33:0] d_info_q [$];
    logic [33:0] i_info_q [$];

    int passed = 0;
    int failed = 0;
    int other_fails = 0;
    int open_count = 0;
    // request seen at the previous rising edge
    logic d_due = 1'b0;
    logic i_due = 1'b0;

    assign fail_count_o = failed + other_fails;
    assign open_count_o = open_count;

    // called by the testbench as it drives a request
    task automatic expect_txn(input string name, input logic is_inst, input logic is_read,
                              input word_t exp, input logic ill);
        if (is_inst)
        begin
            i_name_q.push_back(name);
            i_info_q.push_back({is_read, ill, exp});
        end
        else
        begin
            d_name_q.push_back(name);
            d_info_q.push_back({is_read, ill, exp});
        end
        open_count++;
    endtask

    task automatic take_entry(input logic is_inst, input logic due, output logic have,
                              output string name, output logic [33:0] info);
        have = 1'b0;
        name = "";
        info = '0;
        if (due && (is_inst ? i_name_q.size() : d_name_q.size()) == 0)
        begin
            $display("%s port got a request with no expected value queued",
                     is_inst ? "instruction" : "data");
            other_fails++;
        end
        else if (due)
        begin
            have = 1'b1;
            open_count--;
            if (is_inst)
            begin
                name = i_name_q.pop_front();
                info = i_info_q.pop_front();
            end
            else
            begin
                name = d_name_q.pop_front();
                info = d_info_q.pop_front();
            end
        end
        else if ((is_inst ? i_rvalid_i : d_rvalid_i) !== 1'b0)
        begin
            $display("%s port raised rvalid without a request",
                     is_inst ? "instruction" : "data");
            other_fails++;
        end
    endtask

    task automatic judge(input string name, input logic [33:0] info, input logic rvalid,
                         input word_t rdata, input logic ill_exp);
        word_t exp;
        // out of window reads always carry the marker word
        exp = info[32] ? ILLEGAL_RDATA : info[31:0];
        if (rvalid !== 1'b1)
        begin
            $display("%s: no rvalid one cycle after the request", name);
            failed++;
        end
        else if (info[33] && rdata !== exp)
        begin
            $display("[ERROR] %s expected %h actual %h", name, exp, rdata);
            failed++;
        end
        else if (illegal_i !== ill_exp)
        begin
            $display("[ERROR] %s illegal_memory_o expected %0b actual %0b",
                     name, ill_exp, illegal_i);
            failed++;
        end
        else
        begin
            $display("[PASS] %s", name);
            passed++;
        end
    endtask

    // outputs are settled at the edge, registers move after it
    always @(posedge clk_i)
    begin : score
        logic        d_have;
        logic        i_have;
        string       d_name;
        string       i_name;
        logic [33:0] d_info;
        logic [33:0] i_info;
        logic        ill_exp;
        if (!rst_n_i)
        begin
            d_due = 1'b0;
            i_due = 1'b0;
        end
        else
        begin
            take_entry(1'b0, d_due, d_have, d_name, d_info);
            take_entry(1'b1, i_due, i_have, i_name, i_info);
            // flag is shared, either port can raise it
            ill_exp = (d_have && d_info[32]) || (i_have && i_info[32]);
            if (d_have)
            begin
                judge(d_name, d_info, d_rvalid_i, d_rdata_i, ill_exp);
            end
            if (i_have)
            begin
                judge(i_name, i_info, i_rvalid_i, i_rdata_i, ill_exp);
            end
            if (!d_have && !i_have && illegal_i !== 1'b0)
            begin
                $display("illegal_memory_o raised with no response due");
                other_fails++;
            end
            d_due = d_req_i;
            i_due = i_req_i;
        end
    end

    task automatic print_summary(input int assert_fails);
        $display("%0d tests: %0d passed, %0d failed, %0d other errors, %0d assertion errors",
                 passed + failed, passed, failed, other_fails, assert_fails);
    endtask

endmodule

`default_nettype wire

// File: sim/sram_wrap_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "sram_defs.svh"

module sram_wrap_tb
    import sram_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 3;
    localparam int FILL_WORDS = `SRAM_NUM_BANKS * (2 ** `SRAM_LOG_BANK_WORDS);
    localparam addr_t WIN_END = `SRAM_BASE_ADDR + FILL_WORDS * 4;

    logic  clk;
    logic  rst_n;
    logic  d_req;
    addr_t d_addr;
    logic  d_we;
    be_t   d_be;
    word_t d_wdata;
    logic  d_gnt;
    logic  d_rvalid;
    word_t d_rdata;
    logic  i_req;
    addr_t i_addr;
    logic  i_gnt;
    logic  i_rvalid;
    word_t i_rdata;
    logic  illegal;
    int    fail_count;
    int    open_count;

    // one entry per pattern line
    string name_q [$];
    string port_q [$];
    string op_q [$];
    addr_t addr_q [$];
    be_t   be_q [$];
    word_t wdata_q [$];
    word_t exp_q [$];
    int    cyc_q [$];

    // random words written by F lines, by word offset in the window
    word_t fill_mem [FILL_WORDS];
    int    seed;
    int    tb_errors = 0;
    logic  patterns_loaded = 1'b0;
    logic  d_used;
    logic  i_used;

    sram_wrap i_sram_wrap
    (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .sram_d_req_i     (d_req),
        .sram_d_addr_i    (d_addr),
        .sram_d_we_i      (d_we),
        .sram_d_be_i      (d_be),
        .sram_d_wdata_i   (d_wdata),
        .sram_d_gnt_o     (d_gnt),
        .sram_d_rvalid_o  (d_rvalid),
        .sram_d_rdata_o   (d_rdata),
        .sram_i_req_i     (i_req),
        .sram_i_addr_i    (i_addr),
        .sram_i_gnt_o     (i_gnt),
        .sram_i_rvalid_o  (i_rvalid),
        .sram_i_rdata_o   (i_rdata),
        .illegal_memory_o (illegal)
    );

    sram_wrap_checker u_checker
    (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .d_req_i      (d_req),
        .d_rvalid_i   (d_rvalid),
        .d_rdata_i    (d_rdata),
        .i_req_i      (i_req),
        .i_rvalid_i   (i_rvalid),
        .i_rdata_i    (i_rdata),
        .illegal_i    (illegal),
        .fail_count_o (fail_count),
        .open_count_o (open_count)
    );

    bind sram_wrap sram_wrap_asserts i_sram_wrap_asserts
    (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .d_req_i    (sram_d_req_i),
        .d_gnt_i    (sram_d_gnt_o),
        .d_rvalid_i (sram_d_rvalid_o),
        .i_req_i    (sram_i_req_i),
        .i_gnt_i    (sram_i_gnt_o),
        .i_rvalid_i (sram_i_rvalid_o),
        .illegal_i  (illegal_memory_o)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // end of window is exclusive
    function automatic logic outside_window(input addr_t addr);
        return (addr < `SRAM_BASE_ADDR) || (addr >= WIN_END);
    endfunction

    task automatic report_pattern_error(input string name, input string what);
        $display("pattern %s: %s", name, what);
        tb_errors++;
    endtask

    task automatic load_patterns();
        int    fd;
        int    code;
        string tok;
        string rest;
        string port;
        string op;
        addr_t addr;
        be_t   be;
        word_t wdata;
        word_t exp;
        int    cyc;
        fd = $fopen("sim/sram_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file sim/sram_patterns.txt");
            tb_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fscanf(fd, "%s", tok);
                // comment lines start with a hash
                if (code == 1 && tok[0] == "#")
                begin
                    code = $fgets(rest, fd);
                end
                else if (code == 1)
                begin
                    code = $fscanf(fd, "%s %s %h %h %h %h %d",
                                   port, op, addr, be, wdata, exp, cyc);
                    if (code != 7)
                    begin
                        report_pattern_error(tok, "line has missing or bad fields");
                    end
                    else
                    begin
                        name_q.push_back(tok);
                        port_q.push_back(port);
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        be_q.push_back(be);
                        wdata_q.push_back(wdata);
                        exp_q.push_back(exp);
                        cyc_q.push_back(cyc);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_ports();
        d_req   = 1'b0;
        d_addr  = '0;
        d_we    = 1'b0;
        d_be    = '0;
        d_wdata = '0;
        i_req   = 1'b0;
        i_addr  = '0;
        d_used  = 1'b0;
        i_used  = 1'b0;
    endtask

    task automatic apply_line(input int k);
        logic  ill;
        logic  is_read;
        logic  is_wr;
        word_t wdata;
        word_t exp;
        int    slot;
        ill     = outside_window(addr_q[k]);
        is_read = (op_q[k] == "R") || (op_q[k] == "V");
        is_wr   = (op_q[k] == "W") || (op_q[k] == "F");
        slot    = (addr_q[k] - `SRAM_BASE_ADDR) >> 2;
        wdata   = wdata_q[k];
        exp     = exp_q[k];
        if (!is_read && !is_wr)
        begin
            report_pattern_error(name_q[k], "unknown op");
        end
        else if (port_q[k] != "D" && port_q[k] != "I")
        begin
            report_pattern_error(name_q[k], "port must be D or I");
        end
        else if ((op_q[k] == "F" || op_q[k] == "V") && ill)
        begin
            report_pattern_error(name_q[k], "random fill needs an address inside the window");
        end
        else if ((port_q[k] == "D") ? d_used : i_used)
        begin
            report_pattern_error(name_q[k], "second request on one port in one cycle");
        end
        else if (port_q[k] == "I" && is_wr)
        begin
            report_pattern_error(name_q[k], "instruction port cannot write");
        end
        else
        begin
            if (op_q[k] == "F")
            begin
                wdata = $random(seed);
                fill_mem[slot] = wdata;
            end
            if (op_q[k] == "V")
            begin
                exp = fill_mem[slot];
            end
            if (port_q[k] == "I")
            begin
                i_used = 1'b1;
                i_req  = 1'b1;
                i_addr = addr_q[k];
            end
            else
            begin
                d_used  = 1'b1;
                d_req   = 1'b1;
                d_addr  = addr_q[k];
                d_we    = is_wr;
                d_be    = be_q[k];
                d_wdata = wdata;
            end
            u_checker.expect_txn(name_q[k], port_q[k] == "I", is_read, exp, ill);
        end
    endtask

    initial
    begin
        int k;
        seed  = 32'h8b09_1468;
        rst_n = 1'b0;
        idle_ports();
        load_patterns();
        patterns_loaded = 1'b1;
        if (tb_errors == 0 && name_q.size() == 0)
        begin
            report_pattern_error("file", "holds no transactions");
        end
        if (tb_errors == 0)
        begin
            repeat (RST_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            // quiet cycles, rvalid must stay low
            repeat (4) @(negedge clk);
            k = 0;
            while (k < name_q.size())
            begin
                @(negedge clk);
                idle_ports();
                apply_line(k);
                k++;
                while (k < name_q.size() && cyc_q[k] == 0)
                begin
                    apply_line(k);
                    k++;
                end
            end
            @(negedge clk);
            idle_ports();
            wait (open_count == 0);
            repeat (2) @(negedge clk);
        end
        u_checker.print_summary(i_sram_wrap.i_sram_wrap_asserts.fail_count);
        if (tb_errors == 0 && fail_count == 0
            && i_sram_wrap.i_sram_wrap_asserts.fail_count == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ten cycles per pattern line leaves ample slack
    initial
    begin
        wait (patterns_loaded);
        #((name_q.size() * 10 + RST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired at %0t, responses never drained", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sram_sub.f
+incdir+common
common/sram_pkg.sv
common/bank_wr_if.sv
hdl/sram_addr_decode.sv
sram_bank/sram_macro_1rw1r.sv
sram_bank/sram_bank_array.sv
hdl/sram_read_mux.sv
hdl/sram_wrap.sv
sim/sram_wrap_asserts.sv
sim/sram_wrap_checker.sv
sim/sram_wrap_tb.sv

// File: sim/sram_patterns.txt
# name port op addr be wdata expect cyc
# op W write, R read, F write a random word, V read back that random word
# cyc 1 starts a new cycle, 0 shares the cycle of the line above
wr_b0 D W 80000000 F 11111111 00000000 1
wr_b1 D W 80000104 F 22222222 00000000 1
wr_b2 D W 80000208 F 33333333 00000000 1
wr_b3 D W 800003FC F 44444444 00000000 1
rd_b0_d D R 80000000 F 00000000 11111111 1
rd_b0_i I R 80000000 F 00000000 11111111 0
rd_b1_d D R 80000104 F 00000000 22222222 1
rd_b1_i I R 80000104 F 00000000 22222222 0
rd_b2_d D R 80000208 F 00000000 33333333 1
rd_b2_i I R 80000208 F 00000000 33333333 0
rd_b3_d D R 800003FC F 00000000 44444444 1
rd_b3_i I R 800003FC F 00000000 44444444 0
bb_d_b3 D R 800003FC F 00000000 44444444 1
bb_i_b0 I R 80000000 F 00000000 11111111 0
bb_d_b2 D R 80000208 F 00000000 33333333 1
bb_i_b1 I R 80000104 F 00000000 22222222 0
pw_lo_b1 D W 80000104 3 0000AABB 00000000 1
pw_hi_b1 D W 80000104 8 CC000000 00000000 1
pr_b1 D R 80000104 F 00000000 CC22AABB 1
cf_wr D W 80000208 F 55555555 00000000 1
cf_rd_old I R 80000208 F 00000000 33333333 0
cf_rd_new I R 80000208 F 00000000 55555555 1
il_lo_rd D R 7FFFFFFC F 00000000 DEADBEEF 1
il_hi_rd I R 80000400 F 00000000 DEADBEEF 1
il_hi_wr D W 80000400 F 99999999 00000000 1
il_lo_wr D W 7FFFFFFC F 99999999 00000000 1
il_chk_b0 D R 80000000 F 00000000 11111111 1
il_chk_b3 I R 800003FC F 00000000 44444444 0
rf_wr_b2 D F 80000280 F 00000000 00000000 1
rf_wr_b3 D F 80000380 F 00000000 00000000 1
rf_rd_b2 I V 80000280 F 00000000 00000000 1
rf_rd_b3 D V 80000380 F 00000000 00000000 0
